// ==== pktBuffer.f ====
+incdir+include
verilog/pktBufferPkg.sv
verilog/dualPortRam.sv
verilog/transFifo.sv
verilog/rxFramer.sv
verilog/ackTimer.sv
verilog/txSequencer.sv
verilog/pktBufferTop.sv
test/tbPktBuffer.sv

// ==== test/tbPktBuffer.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

module tbPktBuffer;

    import pktBufferPkg::*;

    // Packets sent over all five behaviors together
    localparam int NUM_PKTS = 13;
    // The overflow packet is the longest one sent
    localparam int MAX_LEN = `PB_DEPTH + 2;
    // Each packet may go out MAX_RETRIES+1 times and sit out the whole ack wait every time
    localparam int CYCLE_LIMIT = 2 * (NUM_PKTS * MAX_LEN
        + NUM_PKTS * (`PB_MAX_RETRIES + 1) * (`PB_ACK_TIMEOUT + MAX_LEN));
    // Cycles the far end takes before it answers, so later packets pile up behind
    localparam int ACK_DELAY = 3;
    localparam int RESP_ACK = 0;
    localparam int RESP_NACK = 1;
    localparam int RESP_SILENT = 2;

    logic clk_i;
    logic rstN_i;
    rxByte_t rx_i;
    logic rxAccept_o;
    logic rxDrop_o;
    txByte_t tx_o;
    logic ack_i;
    logic nack_i;
    logic txGiveUp_o;

    // Words of accepted packets still owed on tx_o, the packet in flight first
    pktWord_t expWords[$];
    // Answer of the far end to each transmission in turn, an empty script means ack
    int respScript[$];
    int errors;
    int cycles;
    int sentCount;
    int acceptedCount;
    int droppedCount;
    int giveUpCount;
    int deliveredCount;
    // Pulses seen on the flag outputs over the whole run
    int acceptPulses;
    int dropPulses;
    int giveUpPulses;
    int txIdx;
    bit busy;

    pktBufferTop i_pktBufferTop (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .rx_i(rx_i),
        .rxAccept_o(rxAccept_o),
        .rxDrop_o(rxDrop_o),
        .tx_o(tx_o),
        .ack_i(ack_i),
        .nack_i(nack_i),
        .txGiveUp_o(txGiveUp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // A packet survives if its bytes XOR to zero and it fits an empty buffer with one slot spare
    function automatic bit expectedAccept(input int len,
                                          input logic [`PB_DATA_WID-1:0] bytes [MAX_LEN]);
        logic [`PB_DATA_WID-1:0] sum;
        sum = '0;
        for (int i = 0; i < len; i++) begin
            sum = sum ^ bytes[i];
        end
        return sum == '0 && len <= `PB_DEPTH - 1;
    endfunction

    task automatic checkWord(input string name, input pktWord_t got, input pktWord_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got last %h data %h, expected last %h data %h",
                     name, got.last, got.data, exp.last, exp.data);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Head packet is finished on tx_o once it is acked or given up
    task automatic dropHead();
        pktWord_t w;
        w = '0;
        while (expWords.size() != 0 && !w.last) begin
            w = expWords.pop_front();
        end
        deliveredCount++;
    endtask

    // Builds a random packet whose last byte is the check byte, wrong on purpose if not good
    task automatic sendPacket(input int len, input bit good);
        logic [`PB_DATA_WID-1:0] bytes [MAX_LEN];
        logic [`PB_DATA_WID-1:0] sum;
        logic [31:0] r;
        bit accept;
        int i;
        sum = '0;
        for (i = 0; i < len - 1; i++) begin
            r = $urandom();
            bytes[i] = r[`PB_DATA_WID-1:0];
            sum = sum ^ bytes[i];
        end
        bytes[len-1] = good ? sum : ~sum;
        accept = expectedAccept(len, bytes);
        for (i = 0; i < len; i++) begin
            @(posedge clk_i);
            #2;
            rx_i = {1'b1, i == len - 1, bytes[i]};
        end
        // The idle cycle after the last byte is when the framer closes the packet
        @(posedge clk_i);
        #2;
        rx_i = '0;
        @(negedge clk_i);
        checkFlag("rxAccept_o", rxAccept_o, accept);
        checkFlag("rxDrop_o", rxDrop_o, !accept);
        if (accept) begin
            acceptedCount++;
            for (i = 0; i < len; i++) begin
                expWords.push_back({i == len - 1, bytes[i]});
            end
        end else begin
            droppedCount++;
        end
    endtask

    task automatic waitDrained();
        while (expWords.size() != 0 || busy) begin
            @(negedge clk_i);
        end
    endtask

    // Compares every byte on tx_o with the head packet, a resend starts from its first byte
    always @(negedge clk_i) begin
        if (rstN_i && tx_o.valid) begin
            if (txIdx >= expWords.size()) begin
                errors++;
                $display("Byte %h came out on tx_o while no packet was owed", tx_o.data);
            end else begin
                checkWord("tx_o", {tx_o.last, tx_o.data}, expWords[txIdx]);
            end
            txIdx++;
            if (tx_o.last) begin
                txIdx = 0;
                sentCount++;
            end
        end
    end

    // A stray or stretched pulse shows up as an extra count at the end of the run
    always @(negedge clk_i) begin
        if (rstN_i) begin
            acceptPulses += rxAccept_o;
            dropPulses += rxDrop_o;
            giveUpPulses += txGiveUp_o;
        end
    end

    // Far end answers each finished transmission and tracks the resends of the head packet
    initial begin : responder
        int resp;
        int tries;
        int handled;
        int k;
        bit fail;
        bit seen;
        ack_i = 1'b0;
        nack_i = 1'b0;
        tries = 0;
        handled = 0;
        forever begin
            wait (sentCount != handled);
            handled++;
            busy = 1'b1;
            resp = (respScript.size() != 0) ? respScript.pop_front() : RESP_ACK;
            if (resp == RESP_SILENT) begin
                seen = 1'b0;
                k = 0;
                // Silence lets the ack timer run out, which gives up at the retry limit
                while (!seen && k < `PB_ACK_TIMEOUT + 1) begin
                    @(negedge clk_i);
                    seen = txGiveUp_o;
                    k++;
                end
            end else begin
                repeat (ACK_DELAY) @(posedge clk_i);
                #2;
                ack_i = resp == RESP_ACK;
                nack_i = resp == RESP_NACK;
                @(negedge clk_i);
                seen = txGiveUp_o;
            end
            fail = resp != RESP_ACK;
            checkFlag("txGiveUp_o", seen, fail && tries == `PB_MAX_RETRIES);
            if (fail && tries == `PB_MAX_RETRIES) begin
                giveUpCount++;
            end
            if (!fail || tries == `PB_MAX_RETRIES) begin
                dropHead();
                tries = 0;
            end else begin
                tries++;
            end
            if (resp != RESP_SILENT) begin
                @(posedge clk_i);
                #2;
                ack_i = 1'b0;
                nack_i = 1'b0;
            end
            busy = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with packets still outstanding", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        void'($urandom(16));
        rstN_i = 1'b0;
        rx_i = '0;
        repeat (4) @(posedge clk_i);
        #2;
        rstN_i = 1'b1;

        // Good packet goes straight through and is acked
        sendPacket($urandom_range(8, 3), 1'b1);
        waitDrained();

        // Bad check byte is dropped and the next packet is untouched
        sendPacket($urandom_range(8, 3), 1'b0);
        sendPacket($urandom_range(8, 3), 1'b1);
        waitDrained();

        // One nack gives one identical resend
        respScript.push_back(RESP_NACK);
        sendPacket($urandom_range(8, 3), 1'b1);
        waitDrained();
        // Three failures in a row end in a give up, then the queued packet follows
        respScript.push_back(RESP_SILENT);
        respScript.push_back(RESP_NACK);
        respScript.push_back(RESP_SILENT);
        sendPacket($urandom_range(8, 3), 1'b1);
        sendPacket($urandom_range(8, 3), 1'b1);
        waitDrained();

        // Overflow drops the long packet but not the one committed ahead of it
        sendPacket(4, 1'b1);
        sendPacket(MAX_LEN, 1'b1);
        waitDrained();
        // A packet of exactly the usable depth still fits an empty buffer
        sendPacket(`PB_DEPTH - 1, 1'b1);
        waitDrained();

        // Packets arriving behind one that awaits ack leave in arrival order
        repeat (4) begin
            sendPacket($urandom_range(5, 2), 1'b1);
        end
        waitDrained();

        repeat (5) @(posedge clk_i);
        if (deliveredCount != acceptedCount) begin
            errors++;
            $display("Only %0d of %0d accepted packets were delivered",
                     deliveredCount, acceptedCount);
        end
        checkCount("rxAccept_o pulses", acceptPulses, acceptedCount);
        checkCount("rxDrop_o pulses", dropPulses, droppedCount);
        checkCount("txGiveUp_o pulses", giveUpPulses, giveUpCount);
        $display("Errors %0d, accepted %0d, delivered %0d, transmissions %0d",
                 errors, acceptedCount, deliveredCount, sentCount);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pktBufferTop.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

module pktBufferTop (
    input wire clk_i,
    input wire rstN_i,
    input wire pktBufferPkg::rxByte_t rx_i,
    output logic rxAccept_o,
    output logic rxDrop_o,
    output pktBufferPkg::txByte_t tx_o,
    input wire ack_i,
    input wire nack_i,
    output logic txGiveUp_o
);

    import pktBufferPkg::*;

    // Framer to FIFO
    logic wValid;
    logic full;
    pktWord_t wWord;
    transCtrl_t fillCtrl;

    // FIFO to memory
    logic wEn;
    logic [`PB_ADDR_WID-1:0] wAddr;
    logic [`PB_ADDR_WID-1:0] rAddr;
    pktWord_t ramWData;
    pktWord_t ramRData;

    // FIFO to sequencer
    logic popData;
    logic dataAvailable;
    pktWord_t popWord;
    transCtrl_t popCtrl;

    // Sequencer to timer
    logic timerStart;
    logic timerStop;
    logic expired;

    rxFramer i_rxFramer (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .rx_i(rx_i),
        .full_i(full),
        .wValid_o(wValid),
        .wWord_o(wWord),
        .fill_o(fillCtrl),
        .rxAccept_o(rxAccept_o),
        .rxDrop_o(rxDrop_o)
    );

    transFifo #(
        .ADDR_WID(`PB_ADDR_WID),
        .DATA_WID($bits(pktWord_t)),
        .ENTRIES(`PB_DEPTH)
    ) i_transFifo (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .wEn_o(wEn),
        .wAddr_o(wAddr),
        .wData_o(ramWData),
        .rAddr_o(rAddr),
        .rData_i(ramRData),
        .fill_i(fillCtrl),
        .dataValid_i(wValid),
        .data_i(wWord),
        .full_o(full),
        .pop_i(popCtrl),
        .popData_i(popData),
        .dataAvailable_o(dataAvailable),
        .data_o(popWord)
    );

    dualPortRam #(
        .ADDR_WID(`PB_ADDR_WID),
        .ENTRIES(`PB_DEPTH)
    ) i_dualPortRam (
        .clk_i(clk_i),
        .wEn_i(wEn),
        .wAddr_i(wAddr),
        .wData_i(ramWData),
        .rAddr_i(rAddr),
        .rData_o(ramRData)
    );

    txSequencer i_txSequencer (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .dataAvailable_i(dataAvailable),
        .data_i(popWord),
        .popData_o(popData),
        .pop_o(popCtrl),
        .timerStart_o(timerStart),
        .timerStop_o(timerStop),
        .expired_i(expired),
        .ack_i(ack_i),
        .nack_i(nack_i),
        .tx_o(tx_o),
        .txGiveUp_o(txGiveUp_o)
    );

    ackTimer i_ackTimer (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .start_i(timerStart),
        .stop_i(timerStop),
        .expired_o(expired)
    );

endmodule

`default_nettype wire

// ==== verilog/txSequencer.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

module txSequencer (
    input wire clk_i,
    input wire rstN_i,
    input wire dataAvailable_i,
    input wire pktBufferPkg::pktWord_t data_i,
    output logic popData_o,
    output pktBufferPkg::transCtrl_t pop_o,
    output logic timerStart_o,
    output logic timerStop_o,
    input wire expired_i,
    input wire ack_i,
    input wire nack_i,
    output pktBufferPkg::txByte_t tx_o,
    output logic txGiveUp_o
);

    import pktBufferPkg::*;

    localparam int RETRY_WID = $clog2(`PB_MAX_RETRIES + 2);

    txState_t state;
    txState_t stateNext;
    // Resends already made for the packet in flight
    logic [RETRY_WID-1:0] retries;
    logic waiting;
    logic respond;
    logic failed;
    logic lastRetry;
    logic commit;
    logic txValid;
    pktWord_t txWord;

    // Words are fetched while idle or sending, one per cycle
    assign popData_o = (state == TX_IDLE || state == TX_SEND) && dataAvailable_i;

    // The last byte leaves during TX_CLOSE and the ack wait starts there
    assign timerStart_o = state == TX_CLOSE;

    assign waiting = state == TX_WAIT;
    assign respond = waiting && (ack_i || nack_i || expired_i);
    // An ack wins over a nack or expiry in the same cycle
    assign failed = respond && !ack_i;
    assign lastRetry = retries == RETRY_WID'(`PB_MAX_RETRIES);
    // At the retry limit the packet is freed anyway
    assign commit = (waiting && ack_i) || (failed && lastRetry);

    assign timerStop_o = waiting && (ack_i || nack_i);
    assign pop_o = {respond, commit};
    assign txGiveUp_o = failed && lastRetry;

    assign tx_o = {txValid, txWord};

    always_comb begin
        stateNext = state;
        case (state)
            TX_IDLE, TX_SEND: begin
                if (popData_o) begin
                    stateNext = data_i.last ? TX_CLOSE : TX_SEND;
                end
            end
            TX_CLOSE: begin
                stateNext = TX_WAIT;
            end
            default: begin
                // After a rollback TX_IDLE sees the same packet available again
                if (respond) begin
                    stateNext = TX_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= TX_IDLE;
            retries <= '0;
            txValid <= 1'b0;
        end else begin
            state <= stateNext;
            txValid <= popData_o;
            if (respond) begin
                retries <= commit ? '0 : retries + 1'b1;
            end
        end
    end

    // Output word register trails the pop by one cycle
    always_ff @(posedge clk_i) begin
        txWord <= data_i;
    end

    // Bytes of a committed packet leave on tx_o back to back since the packet is whole
    noGapWhileSending: assert property (@(posedge clk_i) disable iff (!rstN_i)
        state == TX_SEND |-> tx_o.valid);

endmodule

`default_nettype wire

// ==== verilog/ackTimer.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

module ackTimer (
    input wire clk_i,
    input wire rstN_i,
    input wire start_i,
    input wire stop_i,
    output logic expired_o
);

    localparam int CNT_WID = $clog2(`PB_ACK_TIMEOUT + 1);

    // Holds k in the k-th cycle after start
    logic [CNT_WID-1:0] count;
    logic running;

    assign expired_o = running && count == CNT_WID'(`PB_ACK_TIMEOUT);

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            count <= '0;
            running <= 1'b0;
        end else if (start_i) begin
            // A fresh start also restarts a timer that is still running
            count <= CNT_WID'(1);
            running <= 1'b1;
        end else if (stop_i || expired_o) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rxFramer.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

module rxFramer (
    input wire clk_i,
    input wire rstN_i,
    input wire pktBufferPkg::rxByte_t rx_i,
    input wire full_i,
    output logic wValid_o,
    output pktBufferPkg::pktWord_t wWord_o,
    output pktBufferPkg::transCtrl_t fill_o,
    output logic rxAccept_o,
    output logic rxDrop_o
);

    import pktBufferPkg::*;

    rxState_t state;
    rxState_t stateNext;
    // Running XOR over every byte, check byte included, so a good packet ends at zero
    logic [`PB_DATA_WID-1:0] xorAcc;
    // Sticky once any byte of the packet met a full FIFO
    logic lost;
    logic byteIn;
    logic closing;
    logic checkOk;

    // No byte is taken in the close cycle since the commit must stand alone
    assign byteIn = rx_i.valid && state != RX_CLOSE;
    // Bytes meeting a full FIFO are dropped here and only remembered in lost
    assign wValid_o = byteIn && !full_i;
    assign wWord_o = {rx_i.last, rx_i.data};

    assign closing = state == RX_CLOSE;
    assign checkOk = xorAcc == '0 && !lost;
    assign fill_o = {closing, closing && checkOk};
    assign rxAccept_o = closing && checkOk;
    assign rxDrop_o = closing && !checkOk;

    always_comb begin
        stateNext = state;
        case (state)
            RX_IDLE, RX_BODY: begin
                if (rx_i.valid) begin
                    stateNext = rx_i.last ? RX_CLOSE : RX_BODY;
                end
            end
            // The close cycle always lasts exactly one clock
            default: begin
                stateNext = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= RX_IDLE;
            xorAcc <= '0;
            lost <= 1'b0;
        end else begin
            state <= stateNext;
            if (byteIn) begin
                if (state == RX_IDLE) begin
                    // First byte of a packet starts a fresh check
                    xorAcc <= rx_i.data;
                    lost <= full_i;
                end else begin
                    xorAcc <= xorAcc ^ rx_i.data;
                    lost <= lost || full_i;
                end
            end
        end
    end

    // The sender must leave a gap after each last byte
    gapAfterLast: assert property (@(posedge clk_i) disable iff (!rstN_i)
        state == RX_CLOSE |-> !rx_i.valid);

endmodule

`default_nettype wire

// ==== verilog/transFifo.sv ====
`default_nettype none

module transFifo #(
    parameter int ADDR_WID = 5,
    parameter int DATA_WID = 9,
    parameter int ENTRIES = 0
) (
    input wire clk_i,
    input wire rstN_i,

    // Port pair of the backing memory
    output logic wEn_o,
    output logic [ADDR_WID-1:0] wAddr_o,
    output pktBufferPkg::pktWord_t wData_o,
    output logic [ADDR_WID-1:0] rAddr_o,
    input wire pktBufferPkg::pktWord_t rData_i,

    // Write side, closed by a done pulse on fill_i
    input wire pktBufferPkg::transCtrl_t fill_i,
    input wire dataValid_i,
    input wire pktBufferPkg::pktWord_t data_i,
    output logic full_o,

    // Read side, closed by a done pulse on pop_i
    input wire pktBufferPkg::transCtrl_t pop_i,
    input wire popData_i,
    output logic dataAvailable_o,
    output pktBufferPkg::pktWord_t data_o
);

    import pktBufferPkg::*;

    // Committed counters only move when a transaction closes with success
    logic [ADDR_WID-1:0] fillCount;
    logic [ADDR_WID-1:0] popCount;
    // Tentative counters run ahead with every accepted write or pop
    logic [ADDR_WID-1:0] fillTrans;
    logic [ADDR_WID-1:0] popTrans;
    logic [ADDR_WID-1:0] fillTransNext;
    logic [ADDR_WID-1:0] popTransNext;
    logic writeHs;
    logic readHs;

    generate
        if (DATA_WID != $bits(pktWord_t)) begin : g_widthCheck
            $error("transFifo DATA_WID differs from the stored word width");
        end

        if (ENTRIES <= 0 || ENTRIES == 2 ** ADDR_WID) begin : g_freeWrap
            // Whole address space is backed, so plain overflow wraps the counters
            assign fillTransNext = fillTrans + 1'b1;
            assign popTransNext = popTrans + 1'b1;
        end else begin : g_boundWrap
            // Only part of the space is backed and the counters wrap at the last entry
            assign fillTransNext = (fillTrans == ADDR_WID'(ENTRIES - 1)) ? '0 : fillTrans + 1'b1;
            assign popTransNext = (popTrans == ADDR_WID'(ENTRIES - 1)) ? '0 : popTrans + 1'b1;
        end
    endgenerate

    // One slot stays empty so full and empty remain distinguishable
    assign full_o = fillTransNext == popCount;
    // The reader only sees data whose packet has been committed
    assign dataAvailable_o = popTrans != fillCount;

    assign writeHs = dataValid_i && !full_o;
    assign readHs = popData_i && dataAvailable_o;

    assign wEn_o = writeHs;
    assign wAddr_o = fillTrans;
    assign wData_o = data_i;
    assign rAddr_o = popTrans;
    assign data_o = rData_i;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            fillCount <= '0;
            fillTrans <= '0;
            popCount <= '0;
            popTrans <= '0;
        end else begin
            if (fill_i.done) begin
                if (fill_i.success) begin
                    fillCount <= fillTrans;
                end else begin
                    // Rolled back packet is forgotten and its slots are free again
                    fillTrans <= fillCount;
                end
            end else if (writeHs) begin
                fillTrans <= fillTransNext;
            end

            if (pop_i.done) begin
                if (pop_i.success) begin
                    popCount <= popTrans;
                end else begin
                    // Rewind so the same packet is read once more
                    popTrans <= popCount;
                end
            end else if (readHs) begin
                popTrans <= popTransNext;
            end
        end
    end

    // A done pulse overrides the handshake, so the two must never meet
    fillDoneAlone: assert property (@(posedge clk_i) disable iff (!rstN_i)
        fill_i.done |-> !dataValid_i);
    popDoneAlone: assert property (@(posedge clk_i) disable iff (!rstN_i)
        pop_i.done |-> !popData_i);
    // The framer drops bytes itself when full, so none should reach here
    noWriteWhenFull: assert property (@(posedge clk_i) disable iff (!rstN_i)
        dataValid_i |-> !full_o);

endmodule

`default_nettype wire

// ==== verilog/dualPortRam.sv ====
`default_nettype none

module dualPortRam #(
    parameter int ADDR_WID = 5,
    parameter int ENTRIES = 0
) (
    input wire clk_i,
    input wire wEn_i,
    input wire [ADDR_WID-1:0] wAddr_i,
    input wire pktBufferPkg::pktWord_t wData_i,
    input wire [ADDR_WID-1:0] rAddr_i,
    output pktBufferPkg::pktWord_t rData_o
);

    import pktBufferPkg::*;

    // A non-positive entry count means the full address space is backed
    localparam int DEPTH = (ENTRIES <= 0) ? 2 ** ADDR_WID : ENTRIES;

    pktWord_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wEn_i) begin
            mem[wAddr_i] <= wData_i;
        end
    end

    // Read is combinational so the FIFO output follows its read counter
    assign rData_o = mem[rAddr_i];

endmodule

`default_nettype wire

// ==== verilog/pktBufferPkg.sv ====
`default_nettype none

`include "pktBuffer_defines.svh"

package pktBufferPkg;

    // One stored FIFO entry holds a byte and the flag of the packet's final byte
    typedef struct packed {
        logic last;
        logic [`PB_DATA_WID-1:0] data;
    } pktWord_t;

    // Byte strobe coming in from the link
    typedef struct packed {
        logic valid;
        logic last;
        logic [`PB_DATA_WID-1:0] data;
    } rxByte_t;

    // Byte strobe going out to the far end
    typedef struct packed {
        logic valid;
        logic last;
        logic [`PB_DATA_WID-1:0] data;
    } txByte_t;

    // Ends the open transaction on one FIFO side
    // With success the tentative counter becomes permanent, else it is thrown away
    typedef struct packed {
        logic done;
        logic success;
    } transCtrl_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_BODY,
        RX_CLOSE
    } rxState_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_WAIT,
        TX_CLOSE
    } txState_t;

endpackage

`default_nettype wire

// ==== include/pktBuffer_defines.svh ====
`ifndef PKTBUFFER_DEFINES_SVH
`define PKTBUFFER_DEFINES_SVH

// Width of one payload byte on the link
`define PB_DATA_WID 8

// FIFO address width, wide enough to index every stored word
`define PB_ADDR_WID 5

// Memory backed entries, kept off a power of two so the counters wrap early
`define PB_DEPTH 24

// Cycles the transmitter waits for an ack or nack after the last byte
`define PB_ACK_TIMEOUT 16

// Resends of one packet before the transmitter gives up on it
`define PB_MAX_RETRIES 2

`endif
